// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_coreBusUnit
LOG ?= sim.log
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
RUNFLAGS ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	-./$(OBJ_DIR)/$(TOP) $(RUNFLAGS) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== coreBusPkg.sv ====
`include "coreBus_config.svh"

package coreBusPkg;

    // widths with a meaning
    typedef logic [`DATA_WIDTH-1:0]  addrT;
    typedef logic [`DATA_WIDTH-1:0]  wordT;
    typedef logic [`WSTRB_WIDTH-1:0] strbT;

    // signed and unsigned load kinds
    typedef enum logic [2:0] {
        lb,
        lbu,
        lh,
        lhu,
        lw
    } loadKindT;

    // store widths
    typedef enum logic [1:0] {
        byteW,
        halfW,
        wordW
    } accessWidthT;

    typedef enum logic [2:0] {
        lsIdle,
        lsReadAddr,
        lsReadData,
        lsWriteReq,
        lsWriteResp,
        lsDone
    } lsuStateT;

    typedef enum logic [1:0] {
        fIdle,
        fAddr,
        fData
    } fetchStateT;

    // core-side memory request
    typedef struct packed {
        addrT        addr;
        wordT        wdata;
        logic        isWrite;
        accessWidthT width;
        loadKindT    loadKind;
    } dataReqT;

    // AXI read address and read data channels
    typedef struct packed {
        logic arvalid;
        addrT araddr;
    } axiArT;

    typedef struct packed {
        logic rvalid;
        wordT rdata;
        logic rlast;
    } axiRT;

    // write address and write data travel together
    typedef struct packed {
        logic awvalid;
        addrT awaddr;
        logic wvalid;
        wordT wdata;
        strbT wstrb;
        logic wlast;
    } axiAwWT;

    typedef struct packed {
        logic bvalid;
    } axiBT;

endpackage

// ==== coreBusUnit.sv ====
module coreBusUnit (
    input  logic                clock,
    input  logic                arstN,
    input  logic                fetchEn,
    input  logic                redirect,
    input  coreBusPkg::addrT    redirectPc,
    output logic                instValid,
    output coreBusPkg::wordT    inst,
    output coreBusPkg::addrT    instPc,
    input  logic                memReq,
    input  coreBusPkg::dataReqT dataReq,
    output logic                memBusy,
    output logic                memDone,
    output coreBusPkg::wordT    readData,
    output coreBusPkg::axiArT   ar,
    input  logic                arReady,
    input  coreBusPkg::axiRT    r,
    output logic                rReady,
    output coreBusPkg::axiAwWT  awW,
    input  logic                awReady,
    input  logic                wReady,
    input  coreBusPkg::axiBT    b,
    output logic                bReady
);

    logic             fetchReq;
    logic             lsuReq;
    logic             fetchGrant;
    logic             lsuGrant;
    coreBusPkg::addrT fetchAddr;
    coreBusPkg::addrT lsuAddr;
    coreBusPkg::addrT arAddr;
    logic             fetchArvalid;
    logic             lsuArvalid;
    logic             fetchRready;
    logic             lsuRready;

    // each valid is already gated by its grant
    assign ar     = '{arvalid: fetchArvalid | lsuArvalid, araddr: arAddr};
    assign rReady = fetchRready | lsuRready;

    fetchUnit fetch (
        .clock(clock),
        .arstN(arstN),
        .fetchEn(fetchEn),
        .redirect(redirect),
        .redirectPc(redirectPc),
        .fetchGrant(fetchGrant),
        .arReady(arReady),
        .r(r),
        .fetchReq(fetchReq),
        .fetchAddr(fetchAddr),
        .arvalid(fetchArvalid),
        .rready(fetchRready),
        .instValid(instValid),
        .inst(inst),
        .instPc(instPc)
    );

    loadStoreUnit lsu (
        .clock(clock),
        .arstN(arstN),
        .memReq(memReq),
        .dataReq(dataReq),
        .lsuGrant(lsuGrant),
        .arReady(arReady),
        .r(r),
        .awReady(awReady),
        .wReady(wReady),
        .b(b),
        .lsuReq(lsuReq),
        .lsuAddr(lsuAddr),
        .arvalid(lsuArvalid),
        .rready(lsuRready),
        .awW(awW),
        .bReady(bReady),
        .memBusy(memBusy),
        .memDone(memDone),
        .readData(readData)
    );

    readArbiter arbiter (
        .clock(clock),
        .arstN(arstN),
        .fetchReq(fetchReq),
        .lsuReq(lsuReq),
        .fetchAddr(fetchAddr),
        .lsuAddr(lsuAddr),
        .r(r),
        .rReady(rReady),
        .fetchGrant(fetchGrant),
        .lsuGrant(lsuGrant),
        .araddr(arAddr)
    );

endmodule

// ==== coreBusUnit_assert.sv ====
module coreBusUnit_assert (
    input logic             clock,
    input logic             arstN,
    input logic             grantA,
    input logic             grantB,
    input logic             rDone,
    input logic             arValid,
    input logic             arReady,
    input coreBusPkg::addrT arAddr,
    input logic             awValid,
    input logic             awReady,
    input coreBusPkg::addrT awAddr
);

    int failCount = 0;

    // one owner of the shared read channel until its r handshake
    grantsExclusive: assert property (@(posedge clock) disable iff (!arstN)
        (grantA || grantB) && !rDone |=> $stable(grantA) && $stable(grantB))
        else begin
            failCount = failCount + 1;
            $error("read grant moved to the other unit before the r handshake");
        end

    // valid and address hold until ready
    arHeld: assert property (@(posedge clock) disable iff (!arstN)
        arValid && !arReady |=> arValid && $stable(arAddr))
        else begin
            failCount = failCount + 1;
            $error("arvalid or araddr changed before arready");
        end

    awHeld: assert property (@(posedge clock) disable iff (!arstN)
        awValid && !awReady |=> awValid && $stable(awAddr))
        else begin
            failCount = failCount + 1;
            $error("awvalid or awaddr changed before awready");
        end

endmodule

bind readArbiter coreBusUnit_assert arbiterChecks (
    .clock(clock),
    .arstN(arstN),
    .grantA(fetchGrant),
    .grantB(lsuGrant),
    .rDone(rDone),
    .arValid(1'b0),
    .arReady(1'b0),
    .arAddr(araddr),
    .awValid(1'b0),
    .awReady(1'b0),
    .awAddr(araddr)
);

bind loadStoreUnit coreBusUnit_assert lsuChecks (
    .clock(clock),
    .arstN(arstN),
    .grantA(1'b0),
    .grantB(1'b0),
    .rDone(1'b0),
    .arValid(arvalid),
    .arReady(arReady),
    .arAddr(lsuAddr),
    .awValid(awW.awvalid),
    .awReady(awReady),
    .awAddr(awW.awaddr)
);

// ==== coreBusUnit_trace.txt ====
// columns: op addr data sel expected, all hex
// op 0 fetch count, 1 redirect, 2 store (sel width), 3 load (sel kind), f end
0 00000000 00000004 0 8000000c
2 00001000 11223344 2 00000000
3 00001000 00000000 4 11223344
2 00001002 0000beef 1 00000000
3 00001000 00000000 4 beef3344
2 00001001 000000a5 0 00000000
2 00001003 0000007e 0 00000000
3 00001000 00000000 4 7eefa544
2 00001004 00008001 1 00000000
3 00001004 00000000 4 5a5a8001
3 00002000 00000000 4 5a5a2000
1 80002000 00000003 0 80002008
2 00001010 80f17f92 2 00000000
3 00001010 00000000 0 ffffff92
3 00001010 00000000 1 00000092
3 00001011 00000000 0 0000007f
3 00001011 00000000 1 0000007f
3 00001012 00000000 0 fffffff1
3 00001012 00000000 1 000000f1
3 00001013 00000000 0 ffffff80
3 00001013 00000000 1 00000080
3 00001010 00000000 2 00007f92
3 00001010 00000000 3 00007f92
3 00001012 00000000 2 ffff80f1
3 00001012 00000000 3 000080f1
1 80004000 00000002 0 80004004
f 00000000 00000000 0 00000000

// ==== coreBus_config.svh ====
`ifndef CORE_BUS_CONFIG_SVH
`define CORE_BUS_CONFIG_SVH

// width of data words and byte addresses
`define DATA_WIDTH 32

// one strobe per byte lane
`define WSTRB_WIDTH 4

// first instruction address after reset
`define RESET_PC 32'h8000_0000

// depth in words of the behavioral memory
// used by the testbench only
`define MEM_WORDS 256

`endif

// ==== fetchUnit.sv ====
`include "coreBus_config.svh"

module fetchUnit (
    input  logic             clock,
    input  logic             arstN,
    input  logic             fetchEn,
    input  logic             redirect,
    input  coreBusPkg::addrT redirectPc,
    input  logic             fetchGrant,
    input  logic             arReady,
    input  coreBusPkg::axiRT r,
    output logic             fetchReq,
    output coreBusPkg::addrT fetchAddr,
    output logic             arvalid,
    output logic             rready,
    output logic             instValid,
    output coreBusPkg::wordT inst,
    output coreBusPkg::addrT instPc
);

    coreBusPkg::fetchStateT state;
    coreBusPkg::addrT       pc;
    coreBusPkg::addrT       pendingPc;
    logic                   pendingRedirect;
    logic                   arDone;
    logic                   rDone;
    logic                   inFlight;
    logic                   squash;
    coreBusPkg::addrT       nextTarget;

    assign fetchReq  = (state == coreBusPkg::fAddr);
    assign fetchAddr = pc;
    assign arvalid   = fetchReq && fetchGrant;
    assign rready    = (state == coreBusPkg::fData);
    assign arDone    = arvalid && arReady;
    assign rDone     = rready && r.rvalid && r.rlast;
    // address already on the bus or data still owed
    assign inFlight  = arvalid || rready;

    // a redirect in the completing cycle beats an older one
    assign squash     = pendingRedirect || redirect;
    assign nextTarget = redirect ? redirectPc : pendingPc;

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            state           <= coreBusPkg::fIdle;
            pc              <= `RESET_PC;
            pendingRedirect <= 1'b0;
            instValid       <= 1'b0;
        end else begin
            instValid <= 1'b0;
            case (state)
                coreBusPkg::fIdle: if (fetchEn) state <= coreBusPkg::fAddr;
                coreBusPkg::fAddr: if (arDone) state <= coreBusPkg::fData;
                coreBusPkg::fData: begin
                    if (rDone) begin
                        state <= fetchEn ? coreBusPkg::fAddr : coreBusPkg::fIdle;
                    end
                end
                default: state <= coreBusPkg::fIdle;
            endcase
            if (rDone) begin
                pendingRedirect <= 1'b0;
                if (squash) begin
                    pc <= nextTarget;
                end else begin
                    pc        <= pc + coreBusPkg::addrT'(4);
                    instValid <= 1'b1;
                end
            end else if (redirect) begin
                // read in flight must finish and its result is dropped
                if (inFlight) pendingRedirect <= 1'b1;
                else pc <= redirectPc;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (redirect) pendingPc <= redirectPc;
        if (rDone) begin
            inst   <= r.rdata;
            instPc <= pc;
        end
    end

endmodule

// ==== loadStoreUnit.sv ====
`include "coreBus_config.svh"

module loadStoreUnit (
    input  logic                clock,
    input  logic                arstN,
    input  logic                memReq,
    input  coreBusPkg::dataReqT dataReq,
    input  logic                lsuGrant,
    input  logic                arReady,
    input  coreBusPkg::axiRT    r,
    input  logic                awReady,
    input  logic                wReady,
    input  coreBusPkg::axiBT    b,
    output logic                lsuReq,
    output coreBusPkg::addrT    lsuAddr,
    output logic                arvalid,
    output logic                rready,
    output coreBusPkg::axiAwWT  awW,
    output logic                bReady,
    output logic                memBusy,
    output logic                memDone,
    output coreBusPkg::wordT    readData
);

    coreBusPkg::lsuStateT state;
    coreBusPkg::dataReqT  req;
    logic                 accept;
    logic                 awDone;
    logic                 wDone;
    logic                 awvalid;
    logic                 wvalid;
    logic                 awFire;
    logic                 wFire;
    logic                 arFire;
    logic                 rFire;
    logic                 bFire;
    logic [4:0]           laneShift;
    coreBusPkg::strbT     widthMask;
    coreBusPkg::wordT     laneData;
    coreBusPkg::wordT     loadValue;

    assign accept  = memReq && (state == coreBusPkg::lsIdle);
    assign memBusy = (state != coreBusPkg::lsIdle);
    assign memDone = (state == coreBusPkg::lsDone);

    // reads and writes both go out word aligned
    assign lsuAddr   = {req.addr[`DATA_WIDTH-1:2], 2'b00};
    assign lsuReq    = (state == coreBusPkg::lsReadAddr);
    assign arvalid   = lsuReq && lsuGrant;
    assign rready    = (state == coreBusPkg::lsReadData);
    assign bReady    = (state == coreBusPkg::lsWriteResp);
    assign laneShift = {req.addr[1:0], 3'b000};

    assign awvalid = (state == coreBusPkg::lsWriteReq) && !awDone;
    assign wvalid  = (state == coreBusPkg::lsWriteReq) && !wDone;
    assign awFire  = awvalid && awReady;
    assign wFire   = wvalid && wReady;
    assign arFire  = arvalid && arReady;
    assign rFire   = rready && r.rvalid && r.rlast;
    assign bFire   = bReady && b.bvalid;

    always_comb begin
        case (req.width)
            coreBusPkg::byteW: widthMask = 4'b0001;
            coreBusPkg::halfW: widthMask = 4'b0011;
            default:           widthMask = 4'b1111;
        endcase
    end

    // data and strobes moved onto the addressed lanes
    assign awW = '{
        awvalid: awvalid,
        awaddr:  lsuAddr,
        wvalid:  wvalid,
        wdata:   req.wdata << laneShift,
        wstrb:   widthMask << req.addr[1:0],
        wlast:   1'b1
    };

    // addressed lane down to bit 0 and then extended
    always_comb begin
        laneData = r.rdata >> laneShift;
        case (req.loadKind)
            coreBusPkg::lb:  loadValue = {{(`DATA_WIDTH-8){laneData[7]}}, laneData[7:0]};
            coreBusPkg::lbu: loadValue = {{(`DATA_WIDTH-8){1'b0}}, laneData[7:0]};
            coreBusPkg::lh:  loadValue = {{(`DATA_WIDTH-16){laneData[15]}}, laneData[15:0]};
            coreBusPkg::lhu: loadValue = {{(`DATA_WIDTH-16){1'b0}}, laneData[15:0]};
            default:         loadValue = laneData;
        endcase
    end

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            state  <= coreBusPkg::lsIdle;
            awDone <= 1'b0;
            wDone  <= 1'b0;
        end else begin
            case (state)
                coreBusPkg::lsIdle: begin
                    if (accept) begin
                        state  <= dataReq.isWrite ? coreBusPkg::lsWriteReq
                                                  : coreBusPkg::lsReadAddr;
                        awDone <= 1'b0;
                        wDone  <= 1'b0;
                    end
                end
                coreBusPkg::lsReadAddr: if (arFire) state <= coreBusPkg::lsReadData;
                coreBusPkg::lsReadData: if (rFire) state <= coreBusPkg::lsDone;
                coreBusPkg::lsWriteReq: begin
                    // aw and w may complete in either order
                    if (awFire) awDone <= 1'b1;
                    if (wFire) wDone <= 1'b1;
                    if ((awDone || awFire) && (wDone || wFire)) begin
                        state <= coreBusPkg::lsWriteResp;
                    end
                end
                coreBusPkg::lsWriteResp: if (bFire) state <= coreBusPkg::lsDone;
                default: state <= coreBusPkg::lsIdle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (accept) req <= dataReq;
        if (rFire) readData <= loadValue;
    end

endmodule

// ==== readArbiter.sv ====
module readArbiter (
    input  logic             clock,
    input  logic             arstN,
    input  logic             fetchReq,
    input  logic             lsuReq,
    input  coreBusPkg::addrT fetchAddr,
    input  coreBusPkg::addrT lsuAddr,
    input  coreBusPkg::axiRT r,
    input  logic             rReady,
    output logic             fetchGrant,
    output logic             lsuGrant,
    output coreBusPkg::addrT araddr
);

    logic locked;
    logic ownerLsu;
    logic rDone;

    assign rDone = r.rvalid && rReady && r.rlast;

    // load/store has priority over fetch on a free bus
    // grant stays with the owner while the bus is locked
    assign lsuGrant   = locked ? ownerLsu : lsuReq;
    assign fetchGrant = locked ? !ownerLsu : (fetchReq && !lsuReq);

    assign araddr = lsuGrant ? lsuAddr : fetchAddr;

    // lock from grant through the r handshake
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            locked   <= 1'b0;
            ownerLsu <= 1'b0;
        end else if (!locked) begin
            if (lsuReq || fetchReq) begin
                locked   <= 1'b1;
                ownerLsu <= lsuReq;
            end
        end else if (rDone) begin
            locked <= 1'b0;
        end
    end

endmodule

// ==== tb.f ====
+incdir+.
coreBusPkg.sv
fetchUnit.sv
loadStoreUnit.sv
readArbiter.sv
coreBusUnit.sv
coreBusUnit_assert.sv
tb_coreBusUnit.sv

// ==== tb_coreBusUnit.sv ====
`include "coreBus_config.svh"

module tb_coreBusUnit;

    localparam int WaitLimit = 400;
    localparam int TraceWords = 320;

    logic                clock = 1'b0;
    logic                arstN = 1'b0;
    logic                fetchEn = 1'b1;
    logic                redirect = 1'b0;
    coreBusPkg::addrT    redirectPc = '0;
    logic                instValid;
    coreBusPkg::wordT    inst;
    coreBusPkg::addrT    instPc;
    logic                memReq = 1'b0;
    coreBusPkg::dataReqT dataReq = '0;
    logic                memBusy;
    logic                memDone;
    coreBusPkg::wordT    readData;
    coreBusPkg::axiArT   ar;
    logic                arReady = 1'b0;
    coreBusPkg::axiRT    r = '0;
    logic                rReady;
    coreBusPkg::axiAwWT  awW;
    logic                awReady = 1'b0;
    logic                wReady = 1'b0;
    coreBusPkg::axiBT    b = '0;
    logic                bReady;

    // memory model state tagged with the full word address
    coreBusPkg::wordT memData [0:`MEM_WORDS-1];
    logic [29:0]      memTag [0:`MEM_WORDS-1];
    bit               memValid [0:`MEM_WORDS-1];
    int               seed = 32'h57d4;
    logic             readBusy = 1'b0;
    coreBusPkg::addrT readAddr = '0;
    int               arWait = 0;
    int               rWait = 0;
    logic             awGot = 1'b0;
    logic             wGot = 1'b0;
    coreBusPkg::addrT writeAddr = '0;
    coreBusPkg::wordT writeData = '0;
    coreBusPkg::strbT writeStrb = '0;
    int               awWait = 0;
    int               wWait = 0;

    // instruction stream tracking
    coreBusPkg::addrT expectedPc = `RESET_PC;
    coreBusPkg::addrT lastInstPc = '0;
    int               instCount = 0;
    int               sinceRedirect = 0;
    int               monitorErrors = 0;
    int               testErrors = 0;
    bit               timedOut = 1'b0;
    logic [31:0]      traceMem [0:TraceWords-1];

    always #2 clock = ~clock;

    coreBusUnit dut (
        .clock(clock),
        .arstN(arstN),
        .fetchEn(fetchEn),
        .redirect(redirect),
        .redirectPc(redirectPc),
        .instValid(instValid),
        .inst(inst),
        .instPc(instPc),
        .memReq(memReq),
        .dataReq(dataReq),
        .memBusy(memBusy),
        .memDone(memDone),
        .readData(readData),
        .ar(ar),
        .arReady(arReady),
        .r(r),
        .rReady(rReady),
        .awW(awW),
        .awReady(awReady),
        .wReady(wReady),
        .b(b),
        .bReady(bReady)
    );

    // untouched words hold their byte address xor a marker
    function automatic coreBusPkg::wordT fillWord(input coreBusPkg::addrT addr);
        return addr ^ 32'h5A5A_0000;
    endfunction

    function automatic int randomWait();
        return int'($unsigned($random(seed)) % 4);
    endfunction

    function automatic coreBusPkg::wordT readWord(input coreBusPkg::addrT addr);
        int idx;
        idx = int'(addr[31:2]) % `MEM_WORDS;
        if (memValid[idx] && memTag[idx] == addr[31:2]) return memData[idx];
        return fillWord({addr[31:2], 2'b00});
    endfunction

    task automatic storeWord(input coreBusPkg::addrT addr, input coreBusPkg::wordT data,
                             input coreBusPkg::strbT strb);
        int idx;
        int lane;
        coreBusPkg::wordT cur;
        idx = int'(addr[31:2]) % `MEM_WORDS;
        cur = readWord(addr);
        for (lane = 0; lane < 4; lane++) begin
            if (strb[lane]) cur[lane*8 +: 8] = data[lane*8 +: 8];
        end
        memData[idx]  = cur;
        memTag[idx]   = addr[31:2];
        memValid[idx] = 1'b1;
    endtask

    task automatic compareWord(input string name, input coreBusPkg::wordT actual,
                               input coreBusPkg::wordT expected, output bit good);
        good = (actual === expected);
        if (!good) $display("Fail %s: got %h, expected %h", name, actual, expected);
    endtask

    task automatic compareAddr(input string name, input coreBusPkg::addrT actual,
                               input coreBusPkg::addrT expected, output bit good);
        good = (actual === expected);
        if (!good) $display("Fail %s: got %h, expected %h", name, actual, expected);
    endtask

    task automatic compareBit(input string name, input logic actual,
                              input logic expected, output bit good);
        good = (actual === expected);
        if (!good) $display("Fail %s: got %h, expected %h", name, actual, expected);
    endtask

    // AR and R channels with one read outstanding
    always @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            arReady  <= 1'b0;
            r        <= '0;
            readBusy <= 1'b0;
            arWait   <= 0;
            rWait    <= 0;
        end else begin
            arReady <= 1'b0;
            if (arReady && ar.arvalid) begin
                readBusy <= 1'b1;
                readAddr <= ar.araddr;
                rWait    <= randomWait();
                arWait   <= randomWait();
            end else if (ar.arvalid && !readBusy && !arReady) begin
                if (arWait == 0) arReady <= 1'b1;
                else arWait <= arWait - 1;
            end
            if (r.rvalid && rReady) begin
                r        <= '0;
                readBusy <= 1'b0;
            end else if (readBusy && !r.rvalid) begin
                if (rWait == 0) begin
                    r.rvalid <= 1'b1;
                    r.rdata  <= readWord(readAddr);
                    r.rlast  <= 1'b1;
                end else begin
                    rWait <= rWait - 1;
                end
            end
        end
    end

    // AW and W accepted independently and B once both are in
    always @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            awReady <= 1'b0;
            wReady  <= 1'b0;
            b       <= '0;
            awGot   <= 1'b0;
            wGot    <= 1'b0;
            awWait  <= 0;
            wWait   <= 0;
        end else begin
            awReady <= 1'b0;
            wReady  <= 1'b0;
            if (awReady && awW.awvalid) begin
                awGot     <= 1'b1;
                writeAddr <= awW.awaddr;
                awWait    <= randomWait();
            end else if (awW.awvalid && !awGot && !awReady) begin
                if (awWait == 0) awReady <= 1'b1;
                else awWait <= awWait - 1;
            end
            if (wReady && awW.wvalid) begin
                wGot      <= 1'b1;
                writeData <= awW.wdata;
                writeStrb <= awW.wstrb;
                wWait     <= randomWait();
            end else if (awW.wvalid && !wGot && !wReady) begin
                if (wWait == 0) wReady <= 1'b1;
                else wWait <= wWait - 1;
            end
            if (b.bvalid && bReady) begin
                b <= '0;
            end else if (awGot && wGot && !b.bvalid) begin
                storeWord(writeAddr, writeData, writeStrb);
                b.bvalid <= 1'b1;
                awGot    <= 1'b0;
                wGot     <= 1'b0;
            end
        end
    end

    // every delivered instruction continues the expected PC chain
    always @(posedge clock) begin : instMonitor
        coreBusPkg::addrT nextPc;
        bit good;
        int bad;
        if (arstN) begin
            nextPc = expectedPc;
            bad = 0;
            if (instValid) begin
                compareAddr("instPc", instPc, nextPc, good);
                if (!good) bad++;
                compareWord("inst", inst, fillWord(instPc), good);
                if (!good) bad++;
                nextPc = nextPc + 32'd4;
                instCount     <= instCount + 1;
                sinceRedirect <= sinceRedirect + 1;
                lastInstPc    <= instPc;
            end
            // redirect seen after the beat above
            if (redirect) begin
                nextPc = redirectPc;
                sinceRedirect <= 0;
            end
            expectedPc    <= nextPc;
            monitorErrors <= monitorErrors + bad;
        end
    end

    task automatic waitForInsts(input bit afterRedirect, input int target, output bit ok);
        int cycles;
        ok = 1'b0;
        for (cycles = 0; cycles < WaitLimit; cycles++) begin
            @(posedge clock);
            if ((afterRedirect ? sinceRedirect : instCount) >= target) begin
                ok = 1'b1;
                break;
            end
        end
        if (!ok) $display("timeout: fewer than %0d instructions were delivered", target);
    endtask

    task automatic runMemAccess(input bit isWrite, input coreBusPkg::addrT addr,
                                input coreBusPkg::wordT data, input logic [2:0] sel,
                                output bit ok);
        coreBusPkg::dataReqT req;
        int cycles;
        bit busyGood;
        ok = 1'b0;
        req.addr     = addr;
        req.wdata    = data;
        req.isWrite  = isWrite;
        req.width    = coreBusPkg::accessWidthT'(sel[1:0]);
        req.loadKind = isWrite ? coreBusPkg::lw : coreBusPkg::loadKindT'(sel);
        for (cycles = 0; cycles < WaitLimit; cycles++) begin
            @(posedge clock);
            if (!memBusy) break;
        end
        if (cycles == WaitLimit) begin
            $display("timeout: the load/store unit stayed busy");
            return;
        end
        memReq  <= 1'b1;
        dataReq <= req;
        @(posedge clock);
        memReq <= 1'b0;
        for (cycles = 0; cycles < WaitLimit; cycles++) begin
            @(posedge clock);
            if (memDone) begin
                // busy lasts up to and including the done cycle
                compareBit("memBusy", memBusy, 1'b1, busyGood);
                if (!busyGood) testErrors++;
                ok = 1'b1;
                break;
            end
        end
        if (!ok) $display("timeout: no memDone for the access at %h", addr);
    endtask

    initial begin : stimulus
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] sel;
        logic [31:0] expected;
        bit ok;
        bit good;
        int i;
        int testNum;
        int errorsBefore;
        int assertFails;
        for (i = 0; i < TraceWords; i++) traceMem[i] = 32'hf;
        $readmemh("coreBusUnit_trace.txt", traceMem);
        repeat (2) @(posedge clock);
        arstN <= 1'b1;
        testNum = 0;
        while (!timedOut && testNum < TraceWords / 5 && traceMem[testNum*5] != 32'hf) begin
            op       = traceMem[testNum*5];
            addr     = traceMem[testNum*5+1];
            data     = traceMem[testNum*5+2];
            sel      = traceMem[testNum*5+3];
            expected = traceMem[testNum*5+4];
            errorsBefore = testErrors;
            ok   = 1'b1;
            good = 1'b1;
            case (op)
                32'h0: begin
                    waitForInsts(1'b0, int'(data), ok);
                    if (ok) compareAddr("instPc", lastInstPc, expected, good);
                end
                32'h1: begin
                    @(posedge clock);
                    redirect   <= 1'b1;
                    redirectPc <= addr;
                    @(posedge clock);
                    redirect <= 1'b0;
                    waitForInsts(1'b1, int'(data), ok);
                    if (ok) compareAddr("instPc", lastInstPc, expected, good);
                end
                32'h2: runMemAccess(1'b1, addr, data, sel[2:0], ok);
                32'h3: begin
                    runMemAccess(1'b0, addr, data, sel[2:0], ok);
                    if (ok) compareWord("readData", readData, expected, good);
                end
                default: begin
                    $display("unknown operation %h in trace line %0d", op, testNum);
                    good = 1'b0;
                end
            endcase
            if (!good) testErrors++;
            if (!ok) timedOut = 1'b1;
            $display("test %0d op %0h addr %h: %s", testNum, op[3:0], addr,
                     (ok && testErrors == errorsBefore) ? "ok" : "error");
            testNum++;
        end
        assertFails = dut.arbiter.arbiterChecks.failCount + dut.lsu.lsuChecks.failCount;
        $display("tests %0d, check errors %0d, fetch errors %0d, assertion failures %0d",
                 testNum, testErrors, monitorErrors, assertFails);
        if (!timedOut && testErrors == 0 && monitorErrors == 0 && assertFails == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
